// ==== rtl/core_selector.sv ====
`timescale 1ns/1ps

module core_selector #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 8
) (
  input  logic [CORE_COUNT*$clog2(SLOT_COUNT+1)-1:0] slot_counts,
  input  logic [CORE_COUNT-1:0]                      slot_valids,
  input  logic [CORE_COUNT-1:0]                      income_cores,
  output logic [$clog2(CORE_COUNT)-1:0]              chosen_core,
  output logic                                       chosen_valid
);

  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT+1);
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);
  localparam int LEAVES        = 1 << CORE_ID_WIDTH;
  localparam int NODES         = 2*LEAVES - 1;

  // Heap layout, node n has children 2n+1 and 2n+2, leaves at the end
  logic [SLOT_WIDTH-1:0]    node_count [NODES];
  logic [CORE_ID_WIDTH-1:0] node_id    [NODES];
  logic                     node_valid [NODES];

  always_comb begin
    for (int i = 0; i < LEAVES; i++) begin
      if (i < CORE_COUNT) begin
        node_count[LEAVES-1+i] = slot_counts[i*SLOT_WIDTH +: SLOT_WIDTH];
        node_valid[LEAVES-1+i] = slot_valids[i] && income_cores[i];
      end else begin
        node_count[LEAVES-1+i] = '0;
        node_valid[LEAVES-1+i] = 1'b0;
      end
      node_id[LEAVES-1+i] = CORE_ID_WIDTH'(i);
    end

    // Left subtree holds the lower indices, so it keeps ties
    for (int n = LEAVES-2; n >= 0; n--) begin
      if (node_valid[2*n+2] &&
          (!node_valid[2*n+1] || node_count[2*n+2] > node_count[2*n+1])) begin
        node_count[n] = node_count[2*n+2];
        node_id[n]    = node_id[2*n+2];
        node_valid[n] = 1'b1;
      end else begin
        node_count[n] = node_count[2*n+1];
        node_id[n]    = node_id[2*n+1];
        node_valid[n] = node_valid[2*n+1];
      end
    end
  end

  assign chosen_core  = node_id[0];
  assign chosen_valid = node_valid[0];

endmodule

// ==== rtl/ctrl_out_path.sv ====
`timescale 1ns/1ps

module ctrl_out_path import sched_pkg::*; #(
  parameter int CORE_COUNT      = 4,
  parameter int DONE_FIFO_DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          done_valid,
  output logic                          done_ready,
  input  logic [DESC_WIDTH-1:0]         done_desc,
  input  logic [$clog2(CORE_COUNT)-1:0] done_src,
  output logic [CTRL_WIDTH-1:0]         ctrl_m_tdata,
  output logic                          ctrl_m_tvalid,
  input  logic                          ctrl_m_tready,
  output logic [$clog2(CORE_COUNT)-1:0] ctrl_m_tdest
);

  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);
  localparam int PTR_WIDTH     = (DONE_FIFO_DEPTH > 1) ? $clog2(DONE_FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH     = $clog2(DONE_FIFO_DEPTH+1);
  localparam int ENTRY_WIDTH   = CORE_ID_WIDTH + DESC_WIDTH;

  // Type 0 toward a core means send the packet out
  localparam msg_type_e SEND_OUT_TYPE = MSG_SLOT_FREE;

  logic [ENTRY_WIDTH-1:0]   mem [DONE_FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]     wr_ptr;
  logic [PTR_WIDTH-1:0]     rd_ptr;
  logic [CNT_WIDTH-1:0]     count;
  logic                     push;
  logic                     load;
  logic                     out_ready;
  logic                     out_valid_r;
  logic [DESC_WIDTH-1:0]    out_desc_r;
  logic [CORE_ID_WIDTH-1:0] out_dest_r;
  logic [CORE_ID_WIDTH:0]   startup_cnt;
  logic                     startup_active;

  assign startup_active = (startup_cnt < (CORE_ID_WIDTH+1)'(CORE_COUNT));
  assign done_ready     = (count != CNT_WIDTH'(DONE_FIFO_DEPTH));
  assign push           = done_valid && done_ready;
  assign out_ready      = !startup_active && ctrl_m_tready;
  assign load           = (count != '0) && (!out_valid_r || out_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      out_valid_r <= 1'b0;
      startup_cnt <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DONE_FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (load)
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DONE_FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      if (push && !load)
        count <= count + 1'b1;
      else if (!push && load)
        count <= count - 1'b1;
      if (load)
        out_valid_r <= 1'b1;
      else if (out_ready)
        out_valid_r <= 1'b0;
      if (startup_active && ctrl_m_tready)
        startup_cnt <= startup_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= {done_src, done_desc};
    if (load)
      {out_dest_r, out_desc_r} <= mem[rd_ptr];
  end

  // Startup sweep wins until every core has its reset word
  assign ctrl_m_tvalid = startup_active || out_valid_r;
  assign ctrl_m_tdata  = startup_active ? STARTUP_RESET_WORD : {SEND_OUT_TYPE, out_desc_r};
  assign ctrl_m_tdest  = startup_active ? startup_cnt[CORE_ID_WIDTH-1:0] : out_dest_r;

  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    ctrl_m_tvalid && !ctrl_m_tready |=> $stable(ctrl_m_tdata) && $stable(ctrl_m_tdest));

endmodule

// ==== rtl/port_tagger.sv ====
`timescale 1ns/1ps

module port_tagger import sched_pkg::*; #(
  parameter int INTERFACE_COUNT = 2,
  parameter int CORE_COUNT      = 4,
  parameter int SLOT_COUNT      = 8
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [INTERFACE_COUNT-1:0]             rx_tvalid,
  input  logic [INTERFACE_COUNT-1:0]             rx_tlast,
  output logic [INTERFACE_COUNT-1:0]             rx_tready,
  output logic [INTERFACE_COUNT-1:0]             data_tvalid,
  input  logic [INTERFACE_COUNT-1:0]             data_tready,
  output logic [INTERFACE_COUNT*($clog2(CORE_COUNT) +
               (($clog2(SLOT_COUNT+1) > TAG_WIDTH) ?
                $clog2(SLOT_COUNT+1) : TAG_WIDTH))-1:0] data_tdest,
  input  logic [$clog2(CORE_COUNT)-1:0]          chosen_core,
  input  logic [$clog2(SLOT_COUNT+1)-1:0]        chosen_slot,
  input  logic                                   chosen_valid,
  output logic                                   slot_pop
);

  localparam int SLOT_WIDTH     = $clog2(SLOT_COUNT+1);
  localparam int CORE_ID_WIDTH  = $clog2(CORE_COUNT);
  localparam int SLOT_TAG_WIDTH = (SLOT_WIDTH > TAG_WIDTH) ? SLOT_WIDTH : TAG_WIDTH;
  localparam int DEST_WIDTH     = CORE_ID_WIDTH + SLOT_TAG_WIDTH;
  localparam int IF_WIDTH       = (INTERFACE_COUNT > 1) ? $clog2(INTERFACE_COUNT) : 1;

  logic [DEST_WIDTH-1:0]      dest_r [INTERFACE_COUNT];
  logic [INTERFACE_COUNT-1:0] dest_v;
  logic [INTERFACE_COUNT-1:0] req;
  logic [INTERFACE_COUNT-1:0] last_done;
  logic [IF_WIDTH-1:0]        last_grant;
  logic [IF_WIDTH-1:0]        grant_idx;
  logic                       grant_valid;

  assign req       = ~dest_v & {INTERFACE_COUNT{chosen_valid}};
  assign last_done = rx_tvalid & rx_tlast & data_tready & dest_v;

  // Round-robin search starts just after the previous winner
  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < INTERFACE_COUNT; k++) begin
      idx = (int'(last_grant) + 1 + k) % INTERFACE_COUNT;
      if (!grant_valid && req[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = IF_WIDTH'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_v     <= '0;
      last_grant <= '0;
    end else begin
      dest_v <= dest_v & ~last_done;
      if (grant_valid) begin
        dest_v[grant_idx] <= 1'b1;
        last_grant        <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_valid)
      dest_r[grant_idx] <= {chosen_core, SLOT_TAG_WIDTH'(chosen_slot)};
  end

  for (genvar i = 0; i < INTERFACE_COUNT; i++) begin : g_dest
    assign data_tdest[i*DEST_WIDTH +: DEST_WIDTH] = dest_r[i];
  end

  assign slot_pop    = grant_valid;
  assign data_tvalid = rx_tvalid & dest_v;
  assign rx_tready   = data_tready & dest_v;

  // Pools only hold slots 1 to N, so a popped head of zero is a stale entry
  a_pop_needs_choice: assert property (@(posedge clk) disable iff (rst)
    slot_pop |-> chosen_valid && (chosen_slot != '0));

endmodule

// ==== rtl/sched_pkg.sv ====
package sched_pkg;

  // Control word layout, type on top and descriptor below
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int DESC_WIDTH     = 32;
  localparam int CTRL_WIDTH     = MSG_TYPE_WIDTH + DESC_WIDTH;

  // Slot number position inside slot-free and slot-init descriptors
  localparam int SLOT_FIELD_LSB = 16;

  // Minimum width of the slot part of a data tdest
  localparam int TAG_WIDTH = 5;

  // Incoming control message types
  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_FREE = 4'd0,
    MSG_PKT_DONE  = 4'd1,
    MSG_SLOT_INIT = 4'd3
  } msg_type_e;

  // Sent once to every core after reset
  localparam logic [CTRL_WIDTH-1:0] STARTUP_RESET_WORD = {{(CTRL_WIDTH-1){1'b1}}, 1'b0};

endpackage

// ==== rtl/simple_scheduler.sv ====
`timescale 1ns/1ps

module simple_scheduler import sched_pkg::*; #(
  parameter int CORE_COUNT      = 4,
  parameter int SLOT_COUNT      = 8,
  parameter int INTERFACE_COUNT = 2,
  parameter int DATA_WIDTH      = 64,
  parameter int DONE_FIFO_DEPTH = 8
) (
  input  logic                                   clk,
  input  logic                                   rst,

  input  logic [CTRL_WIDTH-1:0]                  ctrl_s_tdata,
  input  logic                                   ctrl_s_tvalid,
  output logic                                   ctrl_s_tready,
  input  logic [$clog2(CORE_COUNT)-1:0]          ctrl_s_tuser,

  output logic [CTRL_WIDTH-1:0]                  ctrl_m_tdata,
  output logic                                   ctrl_m_tvalid,
  input  logic                                   ctrl_m_tready,
  output logic [$clog2(CORE_COUNT)-1:0]          ctrl_m_tdest,

  input  logic [INTERFACE_COUNT*DATA_WIDTH-1:0]  rx_tdata,
  input  logic [INTERFACE_COUNT*DATA_WIDTH/8-1:0] rx_tkeep,
  input  logic [INTERFACE_COUNT-1:0]             rx_tvalid,
  output logic [INTERFACE_COUNT-1:0]             rx_tready,
  input  logic [INTERFACE_COUNT-1:0]             rx_tlast,

  output logic [INTERFACE_COUNT*DATA_WIDTH-1:0]  data_tdata,
  output logic [INTERFACE_COUNT*DATA_WIDTH/8-1:0] data_tkeep,
  output logic [INTERFACE_COUNT-1:0]             data_tvalid,
  input  logic [INTERFACE_COUNT-1:0]             data_tready,
  output logic [INTERFACE_COUNT-1:0]             data_tlast,
  output logic [INTERFACE_COUNT*($clog2(CORE_COUNT) +
               (($clog2(SLOT_COUNT+1) > TAG_WIDTH) ?
                $clog2(SLOT_COUNT+1) : TAG_WIDTH))-1:0] data_tdest,

  input  logic [CORE_COUNT-1:0]                  income_cores,
  input  logic [$clog2(CORE_COUNT)-1:0]          core_for_slot_count,
  output logic [$clog2(SLOT_COUNT+1)-1:0]        slot_count
);

  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT+1);
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);

  msg_type_e                        msg_type;
  logic                             done_ready;
  logic [CORE_COUNT-1:0]            src_onehot;
  logic [CORE_COUNT-1:0]            insert_v;
  logic [CORE_COUNT-1:0]            init_v;
  logic [SLOT_WIDTH-1:0]            slot_field_r;
  logic [CORE_COUNT*SLOT_WIDTH-1:0] slot_heads;
  logic [CORE_COUNT*SLOT_WIDTH-1:0] slot_counts;
  logic [CORE_COUNT-1:0]            slot_valids;
  logic [CORE_COUNT-1:0]            keeper_pop;
  logic [CORE_ID_WIDTH-1:0]         chosen_core;
  logic                             chosen_valid;
  logic                             tag_pop;

  assign msg_type = msg_type_e'(ctrl_s_tdata[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH]);

  // Only packet-done messages can be held off
  assign ctrl_s_tready = (msg_type == MSG_PKT_DONE) ? done_ready : 1'b1;
  assign src_onehot    = CORE_COUNT'(1) << ctrl_s_tuser;

  always_ff @(posedge clk) begin
    if (rst) begin
      insert_v <= '0;
      init_v   <= '0;
    end else begin
      insert_v <= (ctrl_s_tvalid && msg_type == MSG_SLOT_FREE) ? src_onehot : '0;
      init_v   <= (ctrl_s_tvalid && msg_type == MSG_SLOT_INIT) ? src_onehot : '0;
    end
  end

  always_ff @(posedge clk)
    slot_field_r <= ctrl_s_tdata[SLOT_FIELD_LSB +: SLOT_WIDTH];

  assign keeper_pop = tag_pop ? (CORE_COUNT'(1) << chosen_core) : '0;

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_keeper
    slot_keeper #(
      .SLOT_COUNT(SLOT_COUNT)
    ) i_slot_keeper (
      .clk           (clk),
      .rst           (rst),
      .init_valid    (init_v[c]),
      .init_slots    (slot_field_r),
      .slot_in_valid (insert_v[c]),
      .slot_in       (slot_field_r),
      .slot_out      (slot_heads[c*SLOT_WIDTH +: SLOT_WIDTH]),
      .slot_out_valid(slot_valids[c]),
      .slot_out_pop  (keeper_pop[c]),
      .slot_count    (slot_counts[c*SLOT_WIDTH +: SLOT_WIDTH])
    );
  end

  assign slot_count = slot_counts[core_for_slot_count*SLOT_WIDTH +: SLOT_WIDTH];

  core_selector #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) i_core_selector (
    .slot_counts (slot_counts),
    .slot_valids (slot_valids),
    .income_cores(income_cores),
    .chosen_core (chosen_core),
    .chosen_valid(chosen_valid)
  );

  port_tagger #(
    .INTERFACE_COUNT(INTERFACE_COUNT),
    .CORE_COUNT     (CORE_COUNT),
    .SLOT_COUNT     (SLOT_COUNT)
  ) i_port_tagger (
    .clk         (clk),
    .rst         (rst),
    .rx_tvalid   (rx_tvalid),
    .rx_tlast    (rx_tlast),
    .rx_tready   (rx_tready),
    .data_tvalid (data_tvalid),
    .data_tready (data_tready),
    .data_tdest  (data_tdest),
    .chosen_core (chosen_core),
    .chosen_slot (slot_heads[chosen_core*SLOT_WIDTH +: SLOT_WIDTH]),
    .chosen_valid(chosen_valid),
    .slot_pop    (tag_pop)
  );

  ctrl_out_path #(
    .CORE_COUNT     (CORE_COUNT),
    .DONE_FIFO_DEPTH(DONE_FIFO_DEPTH)
  ) i_ctrl_out_path (
    .clk          (clk),
    .rst          (rst),
    .done_valid   (ctrl_s_tvalid && msg_type == MSG_PKT_DONE),
    .done_ready   (done_ready),
    .done_desc    (ctrl_s_tdata[DESC_WIDTH-1:0]),
    .done_src     (ctrl_s_tuser),
    .ctrl_m_tdata (ctrl_m_tdata),
    .ctrl_m_tvalid(ctrl_m_tvalid),
    .ctrl_m_tready(ctrl_m_tready),
    .ctrl_m_tdest (ctrl_m_tdest)
  );

  assign data_tdata = rx_tdata;
  assign data_tkeep = rx_tkeep;
  assign data_tlast = rx_tlast;

endmodule

// ==== rtl/slot_keeper.sv ====
`timescale 1ns/1ps

module slot_keeper #(
  parameter int SLOT_COUNT = 8
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  init_valid,
  input  logic [$clog2(SLOT_COUNT+1)-1:0]       init_slots,
  input  logic                                  slot_in_valid,
  input  logic [$clog2(SLOT_COUNT+1)-1:0]       slot_in,
  output logic [$clog2(SLOT_COUNT+1)-1:0]       slot_out,
  output logic                                  slot_out_valid,
  input  logic                                  slot_out_pop,
  output logic [$clog2(SLOT_COUNT+1)-1:0]       slot_count
);

  localparam int SLOT_WIDTH = $clog2(SLOT_COUNT+1);
  localparam int PTR_WIDTH  = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;

  logic [SLOT_WIDTH-1:0] mem [SLOT_COUNT];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [SLOT_WIDTH-1:0] count;
  logic                  init_active;
  logic [SLOT_WIDTH-1:0] init_next;
  logic [SLOT_WIDTH-1:0] init_last;
  logic                  do_insert;
  logic [SLOT_WIDTH-1:0] insert_slot;

  // The init sequence owns the write port until slot N is loaded
  assign do_insert   = init_active || slot_in_valid;
  assign insert_slot = init_active ? init_next : slot_in;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      init_active <= 1'b0;
    end else if (init_valid) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      init_active <= (init_slots != '0);
    end else begin
      if (do_insert)
        wr_ptr <= (wr_ptr == PTR_WIDTH'(SLOT_COUNT-1)) ? '0 : wr_ptr + 1'b1;
      if (slot_out_pop)
        rd_ptr <= (rd_ptr == PTR_WIDTH'(SLOT_COUNT-1)) ? '0 : rd_ptr + 1'b1;
      if (do_insert && !slot_out_pop)
        count <= count + 1'b1;
      else if (!do_insert && slot_out_pop)
        count <= count - 1'b1;
      if (init_active && init_next == init_last)
        init_active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (init_valid) begin
      init_next <= SLOT_WIDTH'(1);
      init_last <= init_slots;
    end else if (init_active) begin
      init_next <= init_next + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_insert && !init_valid)
      mem[wr_ptr] <= insert_slot;
  end

  assign slot_out       = mem[rd_ptr];
  assign slot_out_valid = (count != '0);
  assign slot_count     = count;

  a_no_insert_full: assert property (@(posedge clk) disable iff (rst)
    do_insert && !init_valid |-> (count != SLOT_WIDTH'(SLOT_COUNT)) || slot_out_pop);

  // Pops come from the tagger through the selector
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    slot_out_pop |-> slot_out_valid);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module scheduler_tb -f simple_scheduler.f -o scheduler_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/scheduler_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// ==== simple_scheduler.f ====
rtl/sched_pkg.sv
rtl/slot_keeper.sv
rtl/core_selector.sv
rtl/port_tagger.sv
rtl/ctrl_out_path.sv
rtl/simple_scheduler.sv
verification/scheduler_tb.sv

// ==== verification/scheduler_tb.sv ====
`timescale 1ns/1ps

module scheduler_tb import sched_pkg::*; ();

  localparam int CORES  = 4;
  localparam int SLOTS  = 8;
  localparam int IFS    = 2;
  localparam int DW     = 64;
  localparam int SW     = $clog2(SLOTS+1);
  localparam int CIW    = $clog2(CORES);
  localparam int DEST_W = CIW + TAG_WIDTH;

  typedef enum int {K_INIT, K_FREE, K_QUERY, K_PKT, K_STALL, K_DONE} step_kind_e;

  logic                  clk;
  logic                  rst;
  logic [CTRL_WIDTH-1:0] ctrl_s_tdata;
  logic                  ctrl_s_tvalid;
  logic                  ctrl_s_tready;
  logic [CIW-1:0]        ctrl_s_tuser;
  logic [CTRL_WIDTH-1:0] ctrl_m_tdata;
  logic                  ctrl_m_tvalid;
  logic                  ctrl_m_tready;
  logic [CIW-1:0]        ctrl_m_tdest;
  logic [IFS*DW-1:0]     rx_tdata;
  logic [IFS*DW/8-1:0]   rx_tkeep;
  logic [IFS-1:0]        rx_tvalid;
  logic [IFS-1:0]        rx_tready;
  logic [IFS-1:0]        rx_tlast;
  logic [IFS*DW-1:0]     data_tdata;
  logic [IFS*DW/8-1:0]   data_tkeep;
  logic [IFS-1:0]        data_tvalid;
  logic [IFS-1:0]        data_tready;
  logic [IFS-1:0]        data_tlast;
  logic [IFS*DEST_W-1:0] data_tdest;
  logic [CORES-1:0]      income_cores;
  logic [CIW-1:0]        core_for_slot_count;
  logic [SW-1:0]         slot_count;

  // Scoreboard state with pools holding free slots oldest first
  int                    pool [CORES][$];
  bit                    has_dest [IFS];
  int                    dest_core [IFS];
  int                    dest_slot [IFS];
  int                    last_grant;
  int                    pkt_num [IFS];
  logic [CTRL_WIDTH-1:0] exp_data [$];
  int                    exp_dest [$];
  int                    errors;
  bit                    table_ready;

  string                 step_name [$];
  step_kind_e            step_kind [$];
  int                    step_a [$];
  int                    step_b [$];
  logic [CORES-1:0]      step_income [$];

  simple_scheduler i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected == actual) else begin
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Eligible core with the most free slots wins and the lower index breaks a tie
  function automatic int pick_core();
    int best;
    best = -1;
    for (int c = 0; c < CORES; c++) begin
      if (income_cores[c] && pool[c].size() > 0 &&
          (best < 0 || pool[c].size() > pool[best].size()))
        best = c;
    end
    return best;
  endfunction

  // Hand out destinations round-robin until no interface or no core is left
  function automatic void settle();
    int lane;
    int c;
    bit busy;
    busy = 1'b1;
    while (busy) begin
      lane = -1;
      for (int k = 0; k < IFS; k++) begin
        if (lane < 0 && !has_dest[(last_grant + 1 + k) % IFS])
          lane = (last_grant + 1 + k) % IFS;
      end
      c = pick_core();
      if (lane < 0 || c < 0) begin
        busy = 1'b0;
      end else begin
        has_dest[lane]  = 1'b1;
        dest_core[lane] = c;
        dest_slot[lane] = pool[c].pop_front();
        last_grant      = lane;
      end
    end
  endfunction

  function automatic logic [DW-1:0] word_data(input int lane, input int num, input int w);
    return {16'(lane), 16'(num), 32'(w)};
  endfunction

  task automatic add_step(input string name, input step_kind_e kind, input int a,
                          input int b, input logic [CORES-1:0] income);
    step_name.push_back(name);
    step_kind.push_back(kind);
    step_a.push_back(a);
    step_b.push_back(b);
    step_income.push_back(income);
  endtask

  // Leaves tvalid high so the transfer happens on the next rising edge
  task automatic send_msg(input logic [3:0] kind, input logic [DESC_WIDTH-1:0] desc,
                          input int src);
    @(negedge clk);
    ctrl_s_tvalid = 1'b1;
    ctrl_s_tdata  = {kind, desc};
    ctrl_s_tuser  = CIW'(src);
    #1;
    while (!ctrl_s_tready) begin
      @(negedge clk);
      #1;
    end
  endtask

  task automatic send_packet(input string name, input int lane, input int words);
    int sent;
    int exp_tdest;
    bit last_word;
    logic [DW/8-1:0] keep;
    assert (has_dest[lane]) else begin
      errors++;
      $display("Step %s has no destination for interface %0d in the model", name, lane);
    end
    exp_tdest = (dest_core[lane] << TAG_WIDTH) | dest_slot[lane];
    sent = 0;
    while (sent < words) begin
      @(negedge clk);
      last_word = (sent == words - 1);
      // Last word carries a partial keep that changes from packet to packet
      keep = '1;
      if (last_word)
        keep = keep >> (pkt_num[lane] % (DW/8));
      rx_tvalid[lane]             = 1'b1;
      rx_tlast[lane]              = last_word;
      rx_tdata[lane*DW +: DW]     = word_data(lane, pkt_num[lane], sent);
      rx_tkeep[lane*DW/8 +: DW/8] = keep;
      data_tready[lane]           = ($urandom % 4) != 0;
      #1;
      if (rx_tready[lane]) begin
        check_value({name, " tdest"}, exp_tdest, data_tdest[lane*DEST_W +: DEST_W]);
        check_value({name, " tvalid"}, 1, data_tvalid[lane]);
        check_value({name, " tdata"}, rx_tdata[lane*DW +: DW], data_tdata[lane*DW +: DW]);
        check_value({name, " tkeep"}, keep, data_tkeep[lane*DW/8 +: DW/8]);
        check_value({name, " tlast"}, last_word, data_tlast[lane]);
        sent++;
      end
    end
    @(negedge clk);
    rx_tvalid[lane] = 1'b0;
    rx_tlast[lane]  = 1'b0;
    pkt_num[lane]++;
    has_dest[lane] = 1'b0;
    settle();
    repeat (IFS + 2) @(negedge clk);
  endtask

  // Holds the first word of the next packet with no destination available
  task automatic watch_stall(input string name, input int lane, input int cycles);
    assert (!has_dest[lane]) else begin
      errors++;
      $display("Step %s expects interface %0d to wait but the model gave it a slot", name, lane);
    end
    @(negedge clk);
    rx_tvalid[lane]             = 1'b1;
    rx_tlast[lane]              = 1'b0;
    rx_tdata[lane*DW +: DW]     = word_data(lane, pkt_num[lane], 0);
    rx_tkeep[lane*DW/8 +: DW/8] = '1;
    data_tready[lane]           = 1'b1;
    repeat (cycles) begin
      #1;
      check_value({name, " rx_tready"}, 0, rx_tready[lane]);
      @(negedge clk);
    end
    data_tready[lane] = 1'b0;
  endtask

  task automatic run_step(input int s);
    logic [DESC_WIDTH-1:0] desc;
    int a;
    int b;
    a = step_a[s];
    b = step_b[s];
    @(negedge clk);
    income_cores = step_income[s];
    settle();
    repeat (IFS + 2) @(negedge clk);
    case (step_kind[s])
      K_INIT, K_FREE: begin
        desc = DESC_WIDTH'(b << SLOT_FIELD_LSB);
        send_msg((step_kind[s] == K_INIT) ? MSG_SLOT_INIT : MSG_SLOT_FREE, desc, a);
        @(negedge clk);
        ctrl_s_tvalid = 1'b0;
        if (step_kind[s] == K_INIT) begin
          pool[a].delete();
          for (int k = 1; k <= b; k++)
            pool[a].push_back(k);
        end else begin
          pool[a].push_back(b);
        end
        settle();
        repeat (SLOTS + 4) @(negedge clk);
      end
      K_QUERY: begin
        core_for_slot_count = CIW'(a);
        #1;
        check_value(step_name[s], b, slot_count);
      end
      K_PKT:   send_packet(step_name[s], a, b);
      K_STALL: watch_stall(step_name[s], a, b);
      K_DONE: begin
        for (int k = 0; k < b; k++) begin
          desc = {8'hd0, 8'(s), 16'(k)};
          send_msg(MSG_PKT_DONE, desc, a);
          // Forwarded with type zero to the sending core
          exp_data.push_back({4'h0, desc});
          exp_dest.push_back(a);
        end
        @(negedge clk);
        ctrl_s_tvalid = 1'b0;
      end
      default: ;
    endcase
  endtask

  task automatic build_table();
    add_step("init_core0", K_INIT, 0, 3, 4'b0000);
    add_step("init_core1", K_INIT, 1, 5, 4'b0000);
    add_step("init_core2", K_INIT, 2, 8, 4'b0000);
    add_step("init_core3", K_INIT, 3, 2, 4'b0000);
    add_step("count_core0", K_QUERY, 0, 3, 4'b0000);
    add_step("count_core1", K_QUERY, 1, 5, 4'b0000);
    add_step("count_core2", K_QUERY, 2, 8, 4'b0000);
    add_step("count_core3", K_QUERY, 3, 2, 4'b0000);
    add_step("pkt_a_if0", K_PKT, 0, 3, 4'b1011);
    add_step("pkt_b_if1", K_PKT, 1, 2, 4'b1011);
    add_step("pkt_c_if0", K_PKT, 0, 1, 4'b1011);
    add_step("free_core1_slot1", K_FREE, 1, 1, 4'b1011);
    add_step("count_core1_after_free", K_QUERY, 1, 3, 4'b1011);
    add_step("pkt_d_if1", K_PKT, 1, 4, 4'b1011);
    add_step("pkt_e_if0", K_PKT, 0, 2, 4'b1011);
    add_step("pkt_f_if1", K_PKT, 1, 1, 4'b1011);
    add_step("pkt_g_if0", K_PKT, 0, 3, 4'b1011);
    add_step("pkt_h_if1", K_PKT, 1, 2, 4'b1011);
    add_step("count_core2_untouched", K_QUERY, 2, 8, 4'b1011);
    add_step("pkt_i_if0", K_PKT, 0, 1, 4'b1000);
    add_step("pkt_j_if1", K_PKT, 1, 1, 4'b1000);
    add_step("stall_if1", K_STALL, 1, 6, 4'b1000);
    add_step("free_core3_slot1", K_FREE, 3, 1, 4'b1000);
    add_step("pkt_k_if1", K_PKT, 1, 2, 4'b1000);
    add_step("pkt_l_if0", K_PKT, 0, 1, 4'b1000);
    add_step("count_core3_empty", K_QUERY, 3, 0, 4'b1000);
    add_step("done_burst_core2", K_DONE, 2, 12, 4'b0000);
    add_step("done_burst_core1", K_DONE, 1, 5, 4'b0000);
    add_step("done_core3", K_DONE, 3, 1, 4'b0000);
    add_step("done_core0", K_DONE, 0, 1, 4'b0000);
  endtask

  initial begin : ctrl_out_monitor
    int n;
    n = 0;
    ctrl_m_tready = 1'b0;
    forever begin
      @(negedge clk);
      ctrl_m_tready = ($urandom % 2) == 1;
      #1;
      if (!rst && ctrl_m_tvalid && ctrl_m_tready) begin
        assert (exp_data.size() != 0) else begin
          errors++;
          $display("Control output sent a message to core %0d that nobody expected",
                   ctrl_m_tdest);
        end
        if (exp_data.size() != 0) begin
          check_value($sformatf("ctrl_out_%0d data", n), exp_data[0], ctrl_m_tdata);
          check_value($sformatf("ctrl_out_%0d dest", n), exp_dest[0], ctrl_m_tdest);
          void'(exp_data.pop_front());
          void'(exp_dest.pop_front());
        end
        n++;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = step_name.size() * 60 + 400;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run is stuck", limit);
    $display("Regression failed");
    $finish;
  end

  initial begin : main_sequence
    void'($urandom(72670));
    errors              = 0;
    rst                 = 1'b1;
    ctrl_s_tdata        = '0;
    ctrl_s_tvalid       = 1'b0;
    ctrl_s_tuser        = '0;
    rx_tdata            = '0;
    rx_tkeep            = '1;
    rx_tvalid           = '0;
    rx_tlast            = '0;
    data_tready         = '1;
    income_cores        = '0;
    core_for_slot_count = '0;
    last_grant          = 0;
    for (int i = 0; i < IFS; i++) begin
      has_dest[i] = 1'b0;
      pkt_num[i]  = 0;
    end
    // Startup sweep goes to every core in ascending order
    for (int c = 0; c < CORES; c++) begin
      exp_data.push_back(STARTUP_RESET_WORD);
      exp_dest.push_back(c);
    end
    build_table();
    table_ready = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    #1;
    check_value("after_reset ctrl_m_tvalid", 1, ctrl_m_tvalid);
    check_value("after_reset data_tvalid", 0, data_tvalid);
    check_value("after_reset rx_tready", 0, rx_tready);
    check_value("after_reset ctrl_s_tready", 1, ctrl_s_tready);
    for (int s = 0; s < step_name.size(); s++)
      run_step(s);
    while (exp_data.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    $display("Finished %0d steps with %0d errors", step_name.size(), errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
